// File: all.f
hw/mandel_pkg.sv
hw/complex_mult.sv
hw/signed_cast.sv
hw/mandelbrot_pxl.sv
hw/frame_scanner.sv
hw/mandel_top.sv
bench/mandel_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module mandel_tb -Mdir obj_dir -o mandel_sim
	./obj_dir/mandel_sim | tee sim.log
	@grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/mandel_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mandel_tb;

    localparam int n_fixed  = 7;
    localparam int n_random = 6;
    localparam int n_frames = n_fixed + n_random;

    // One in Q8.16.
    localparam int one = 1 << mandel_pkg::data_point;

    logic                                     clk;
    logic                                     rst_n;
    logic                                     start;
    logic signed [mandel_pkg::data_width-1:0] origin_re;
    logic signed [mandel_pkg::data_width-1:0] origin_im;
    logic signed [mandel_pkg::data_width-1:0] step;
    logic        [mandel_pkg::dim_width-1:0]  width;
    logic        [mandel_pkg::dim_width-1:0]  height;
    logic        [mandel_pkg::iter_width-1:0] iters;
    wire                                      busy;
    wire                                      pixel_valid;
    wire         [mandel_pkg::dim_width-1:0]  pixel_col;
    wire         [mandel_pkg::dim_width-1:0]  pixel_row;
    wire         [mandel_pkg::iter_width-1:0] pixel_count;
    wire                                      frame_done;

    // Frame table, one row per frame.
    logic signed [mandel_pkg::data_width-1:0] t_origin_re [n_frames];
    logic signed [mandel_pkg::data_width-1:0] t_origin_im [n_frames];
    logic signed [mandel_pkg::data_width-1:0] t_step      [n_frames];
    int                                       t_width     [n_frames];
    int                                       t_height    [n_frames];
    int                                       t_iters     [n_frames];
    bit                                       t_restart   [n_frames];

    int error_count;
    int check_count;
    int pixel_total;
    int budget_cycles;

    mandel_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .origin_re   (origin_re),
        .origin_im   (origin_im),
        .step        (step),
        .width       (width),
        .height      (height),
        .iters       (iters),
        .busy        (busy),
        .pixel_valid (pixel_valid),
        .pixel_col   (pixel_col),
        .pixel_row   (pixel_row),
        .pixel_count (pixel_count),
        .frame_done  (frame_done)
    );

    always #4 clk = ~clk;

    // Low word bits read back as a signed Q8.16 value.
    function automatic longint wrap_word(input longint v);
        logic signed [mandel_pkg::data_width-1:0] w;
        w = v[mandel_pkg::data_width-1:0];
        return longint'(w);
    endfunction

    // Escape-time count for one c, z starting at zero.
    function automatic int escape_count(input longint c_re, input longint c_im, input int limit);
        longint z_re;
        longint z_im;
        longint n_re;
        longint n_im;
        longint hi;
        longint lo;
        int     n;
        z_re = 0;
        z_im = 0;
        hi   = (longint'(1) <<< (mandel_pkg::data_width - 1)) - 1;
        lo   = -hi - 1;
        for (n = 1; n <= limit; n++) begin
            n_re = z_re * z_re - z_im * z_im;
            n_im = 2 * z_re * z_im;
            // Arithmetic shift floors toward minus infinity.
            n_re = (n_re >>> mandel_pkg::data_point) + c_re;
            n_im = (n_im >>> mandel_pkg::data_point) + c_im;
            if (n_re > hi || n_re < lo || n_im > hi || n_im < lo) begin
                return n;
            end
            z_re = n_re;
            z_im = n_im;
        end
        return limit;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] actual,
                                 input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic report_problem(input string msg);
        error_count++;
        $display("ERROR: %s", msg);
    endtask

    task automatic set_row(input int f, input int ore, input int oim, input int stp,
                           input int w, input int h, input int it, input bit restart);
        t_origin_re[f] = ore[mandel_pkg::data_width-1:0];
        t_origin_im[f] = oim[mandel_pkg::data_width-1:0];
        t_step[f]      = stp[mandel_pkg::data_width-1:0];
        t_width[f]     = w;
        t_height[f]    = h;
        t_iters[f]     = it;
        t_restart[f]   = restart;
    endtask

    task automatic fill_table();
        int f;
        // Near 0 and near -1, all inside the set.
        set_row(0, -one / 16, -one / 16, one / 32, 4, 4, 20, 0);
        set_row(1, -one - one / 16, -one / 16, one / 32, 4, 4, 30, 0);
        // Wide window past |c| = 2.
        set_row(2, -5 * one / 2, -3 * one / 2, one / 2, 8, 7, 16, 0);
        // Extreme c overflows on the second pass.
        set_row(3, -128 * one, -128 * one, 64 * one, 4, 4, 8, 0);
        set_row(4, -2 * one, -one, one / 2, 5, 4, 1, 0);
        // Second start is pulsed during this frame.
        set_row(5, -2 * one, -5 * one / 4, one / 4, 6, 5, 12, 1);
        set_row(6, one / 4, 0, one / 256, 1, 3, 60, 0);
        for (f = n_fixed; f < n_frames; f++) begin
            set_row(f,
                    int'($urandom % (4 * one)) - 5 * one / 2,
                    int'($urandom % (3 * one)) - 3 * one / 2,
                    1 + int'($urandom % (one / 2)),
                    1 + int'($urandom % 6),
                    1 + int'($urandom % 6),
                    1 + int'($urandom % 40),
                    0);
        end
    endtask

    task automatic run_frame(input int f);
        int     w;
        int     total;
        int     seen;
        int     errors_before;
        int     expected;
        bit     poked;
        bit     done;
        longint c_re;
        longint c_im;
        w             = t_width[f];
        total         = t_width[f] * t_height[f];
        seen          = 0;
        errors_before = error_count;
        poked         = 0;
        done          = 0;
        @(posedge clk);
        #1;
        origin_re = t_origin_re[f];
        origin_im = t_origin_im[f];
        step      = t_step[f];
        width     = t_width[f][mandel_pkg::dim_width-1:0];
        height    = t_height[f][mandel_pkg::dim_width-1:0];
        iters     = t_iters[f][mandel_pkg::iter_width-1:0];
        start     = 1'b1;
        while (!done) begin
            @(posedge clk);
            #1;
            start = 1'b0;
            if (pixel_valid) begin
                if (seen >= total) begin
                    report_problem($sformatf("frame %0d gave more than %0d pixels", f, total));
                end else begin
                    c_re = wrap_word(longint'(t_origin_re[f])
                                     + longint'(seen % w) * longint'(t_step[f]));
                    c_im = wrap_word(longint'(t_origin_im[f])
                                     + longint'(seen / w) * longint'(t_step[f]));
                    expected = escape_count(c_re, c_im, t_iters[f]);
                    compare_value("pixel_col", pixel_col, seen % w);
                    compare_value("pixel_row", pixel_row, seen / w);
                    compare_value("pixel_count", pixel_count, expected);
                end
                seen++;
            end
            if (frame_done) begin
                compare_value("pixel_valid", pixel_valid, 1);
                compare_value("busy", busy, 0);
                if (seen != total) begin
                    report_problem($sformatf("frame %0d ended after %0d of %0d pixels",
                                             f, seen, total));
                end
                done = 1;
            end else begin
                compare_value("busy", busy, 1);
                if (t_restart[f] && !poked && seen > 0) begin
                    // A different window, which must not take effect.
                    origin_re = t_origin_re[f] + 24'sh010000;
                    origin_im = t_origin_im[f] - 24'sh008000;
                    step      = t_step[f] + t_step[f];
                    width     = 1;
                    height    = 1;
                    iters     = 3;
                    start     = 1'b1;
                    poked     = 1;
                end
            end
        end
        repeat (3) begin
            @(posedge clk);
            #1;
            compare_value("frame_done", frame_done, 0);
            compare_value("pixel_valid", pixel_valid, 0);
            compare_value("busy", busy, 0);
        end
        pixel_total += seen;
        $display("frame %0d: %0dx%0d, iters %0d, %0d pixels, %0d mismatches",
                 f, t_width[f], t_height[f], t_iters[f], seen, error_count - errors_before);
    endtask

    initial begin
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a frame never finished", budget_cycles);
        $display("Errors found");
        $finish;
    end

    initial begin
        int f;
        clk       = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        origin_re = '0;
        origin_im = '0;
        step      = '0;
        width     = '0;
        height    = '0;
        iters     = '0;
        void'($urandom(73));
        fill_table();
        for (f = 0; f < n_frames; f++) begin
            budget_cycles += t_width[f] * t_height[f] * (4 * t_iters[f] + 4);
        end
        budget_cycles += 1000;

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (5) begin
            @(posedge clk);
            #1;
            compare_value("busy", busy, 0);
            compare_value("pixel_valid", pixel_valid, 0);
            compare_value("frame_done", frame_done, 0);
        end
        $display("reset: outputs idle, %0d mismatches", error_count);

        for (f = 0; f < n_frames; f++) begin
            run_frame(f);
        end

        $display("%0d frames, %0d pixels, %0d checks, %0d errors",
                 n_frames, pixel_total, check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/mandel_top.sv
`timescale 1ns/10ps
`default_nettype none

module mandel_top (
    input  wire                                       clk,
    input  wire                                       rst_n,
    input  wire                                       start,
    input  wire signed [mandel_pkg::data_width-1:0]   origin_re,
    input  wire signed [mandel_pkg::data_width-1:0]   origin_im,
    input  wire signed [mandel_pkg::data_width-1:0]   step,
    input  wire        [mandel_pkg::dim_width-1:0]    width,
    input  wire        [mandel_pkg::dim_width-1:0]    height,
    input  wire        [mandel_pkg::iter_width-1:0]   iters,
    output wire                                       busy,
    output wire                                       pixel_valid,
    output wire        [mandel_pkg::dim_width-1:0]    pixel_col,
    output wire        [mandel_pkg::dim_width-1:0]    pixel_row,
    output wire        [mandel_pkg::iter_width-1:0]   pixel_count,
    output wire                                       frame_done
);

    wire                                     pix_start;
    wire signed [mandel_pkg::data_width-1:0] c_re;
    wire signed [mandel_pkg::data_width-1:0] c_im;
    wire        [mandel_pkg::iter_width-1:0] iters_q;
    wire                                     pix_busy;
    wire        [mandel_pkg::iter_width-1:0] pix_count;
    wire                                     pix_done;

    frame_scanner scanner_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .origin_re   (origin_re),
        .origin_im   (origin_im),
        .step        (step),
        .width       (width),
        .height      (height),
        .iters       (iters),
        .pix_busy    (pix_busy),
        .pix_count   (pix_count),
        .pix_done    (pix_done),
        .busy        (busy),
        .pix_start   (pix_start),
        .c_re        (c_re),
        .c_im        (c_im),
        .iters_q     (iters_q),
        .pixel_valid (pixel_valid),
        .pixel_col   (pixel_col),
        .pixel_row   (pixel_row),
        .pixel_count (pixel_count),
        .frame_done  (frame_done)
    );

    mandelbrot_pxl pxl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_start (pix_start),
        .c_re      (c_re),
        .c_im      (c_im),
        .iters     (iters_q),
        .pix_busy  (pix_busy),
        .pix_count (pix_count),
        .pix_done  (pix_done)
    );

endmodule

`default_nettype wire

// File: hw/frame_scanner.sv
`timescale 1ns/10ps
`default_nettype none

module frame_scanner (
    input  wire                                        clk,
    input  wire                                        rst_n,
    input  wire                                        start,
    input  wire  signed [mandel_pkg::data_width-1:0]   origin_re,
    input  wire  signed [mandel_pkg::data_width-1:0]   origin_im,
    input  wire  signed [mandel_pkg::data_width-1:0]   step,
    input  wire         [mandel_pkg::dim_width-1:0]    width,
    input  wire         [mandel_pkg::dim_width-1:0]    height,
    input  wire         [mandel_pkg::iter_width-1:0]   iters,
    input  wire                                        pix_busy,
    input  wire         [mandel_pkg::iter_width-1:0]   pix_count,
    input  wire                                        pix_done,
    output logic                                       busy,
    output logic                                       pix_start,
    output logic signed [mandel_pkg::data_width-1:0]   c_re,
    output logic signed [mandel_pkg::data_width-1:0]   c_im,
    output logic        [mandel_pkg::iter_width-1:0]   iters_q,
    output logic                                       pixel_valid,
    output logic        [mandel_pkg::dim_width-1:0]    pixel_col,
    output logic        [mandel_pkg::dim_width-1:0]    pixel_row,
    output logic        [mandel_pkg::iter_width-1:0]   pixel_count,
    output logic                                       frame_done
);

    logic                                     waiting;
    logic                                     accept;
    logic [mandel_pkg::dim_width-1:0]         col;
    logic [mandel_pkg::dim_width-1:0]         row;
    logic [mandel_pkg::dim_width-1:0]         width_q;
    logic [mandel_pkg::dim_width-1:0]         height_q;
    logic signed [mandel_pkg::data_width-1:0] origin_re_q;
    logic signed [mandel_pkg::data_width-1:0] step_q;
    logic                                     last_col;
    logic                                     last_row;

    assign accept   = start & ~busy;
    assign last_col = (col == width_q - 1'b1);
    assign last_row = (row == height_q - 1'b1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            waiting     <= 1'b0;
            pix_start   <= 1'b0;
            pixel_valid <= 1'b0;
            frame_done  <= 1'b0;
        end else begin
            pix_start   <= 1'b0;
            pixel_valid <= pix_done;
            frame_done  <= 1'b0;
            if (accept) begin
                busy    <= 1'b1;
                waiting <= 1'b0;
            end else if (busy) begin
                // Next pixel once the engine is idle again.
                if (!waiting && !pix_busy) begin
                    pix_start <= 1'b1;
                    waiting   <= 1'b1;
                end
                if (pix_done) begin
                    waiting <= 1'b0;
                    if (last_col && last_row) begin
                        busy       <= 1'b0;
                        frame_done <= 1'b1;
                    end
                end
            end
        end
    end

    // Window capture and the pixel walk.
    always_ff @(posedge clk) begin
        if (accept) begin
            origin_re_q <= origin_re;
            step_q      <= step;
            width_q     <= width;
            height_q    <= height;
            iters_q     <= iters;
            col         <= '0;
            row         <= '0;
            c_re        <= origin_re;
            c_im        <= origin_im;
        end else if (pix_done) begin
            pixel_col   <= col;
            pixel_row   <= row;
            pixel_count <= pix_count;
            if (last_col) begin
                col  <= '0;
                row  <= row + 1'b1;
                c_re <= origin_re_q;
                c_im <= c_im + step_q;
            end else begin
                col  <= col + 1'b1;
                c_re <= c_re + step_q;
            end
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        pix_start |-> !pix_busy);

endmodule

`default_nettype wire

// File: hw/mandelbrot_pxl.sv
`timescale 1ns/10ps
`default_nettype none

module mandelbrot_pxl (
    input  wire                                        clk,
    input  wire                                        rst_n,
    input  wire                                        pix_start,
    input  wire  signed [mandel_pkg::data_width-1:0]   c_re,
    input  wire  signed [mandel_pkg::data_width-1:0]   c_im,
    input  wire         [mandel_pkg::iter_width-1:0]   iters,
    output logic                                       pix_busy,
    output logic        [mandel_pkg::iter_width-1:0]   pix_count,
    output logic                                       pix_done
);

    // High while the FSM iterates.
    logic                                   busy_q;
    logic                                   start_q;
    logic [mandel_pkg::iter_width-1:0]      count_q;
    logic [mandel_pkg::iter_width-1:0]      count_next;
    logic                                   finish;

    logic                                   op_strobe;
    logic signed [mandel_pkg::data_width-1:0] z_re;
    logic signed [mandel_pkg::data_width-1:0] z_im;

    logic signed [mandel_pkg::mult_width-1:0] mult_re;
    logic signed [mandel_pkg::mult_width-1:0] mult_im;
    logic                                     mult_valid;

    logic signed [mandel_pkg::sum_width-1:0]  sum_re;
    logic signed [mandel_pkg::sum_width-1:0]  sum_im;
    logic                                     sum_valid;

    logic signed [mandel_pkg::data_width-1:0] op_re;
    logic signed [mandel_pkg::data_width-1:0] op_im;
    logic                                     op_ovf_re;
    logic                                     op_ovf_im;
    logic                                     op_valid;

    assign count_next = count_q + 1'b1;
    assign finish     = op_valid & (op_ovf_re | op_ovf_im | (count_next == iters));

    // First pass squares zero.
    // Later passes feed the cast results straight back.
    assign op_strobe = start_q | (op_valid & ~finish);
    assign z_re      = op_valid ? op_re : '0;
    assign z_im      = op_valid ? op_im : '0;

    assign pix_done  = finish;
    assign pix_count = count_next;
    assign pix_busy  = busy_q & ~finish;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            start_q <= 1'b0;
            count_q <= '0;
        end else if (!busy_q) begin
            start_q <= pix_start;
            count_q <= '0;
            if (pix_start) begin
                busy_q <= 1'b1;
            end
        end else begin
            start_q <= 1'b0;
            if (op_valid) begin
                count_q <= count_next;
            end
            if (finish) begin
                busy_q <= 1'b0;
            end
        end
    end

    complex_mult #(
        .din1_width (mandel_pkg::data_width),
        .din2_width (mandel_pkg::data_width)
    ) mult_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .din1_re    (z_re),
        .din1_im    (z_im),
        .din2_re    (z_re),
        .din2_im    (z_im),
        .din_valid  (op_strobe),
        .dout_re    (mult_re),
        .dout_im    (mult_im),
        .dout_valid (mult_valid)
    );

    // Drop the extra fraction bits, then add c.
    always_ff @(posedge clk) begin
        sum_re <= $signed(mult_re[mandel_pkg::mult_width-1:mandel_pkg::data_point]) + c_re;
        sum_im <= $signed(mult_im[mandel_pkg::mult_width-1:mandel_pkg::data_point]) + c_im;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= mult_valid;
        end
    end

    signed_cast #(
        .din_width  (mandel_pkg::sum_width),
        .din_point  (mandel_pkg::data_point),
        .dout_width (mandel_pkg::data_width),
        .dout_point (mandel_pkg::data_point)
    ) cast_re_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .din        (sum_re),
        .din_valid  (sum_valid),
        .dout       (op_re),
        .ovf        (op_ovf_re),
        .dout_valid (op_valid)
    );

    signed_cast #(
        .din_width  (mandel_pkg::sum_width),
        .din_point  (mandel_pkg::data_point),
        .dout_width (mandel_pkg::data_width),
        .dout_point (mandel_pkg::data_point)
    ) cast_im_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .din        (sum_im),
        .din_valid  (sum_valid),
        .dout       (op_im),
        .ovf        (op_ovf_im),
        .dout_valid ()
    );

    a_iters_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        pix_start |-> iters != '0);

    a_op_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        op_valid |-> busy_q);

endmodule

`default_nettype wire

// File: hw/signed_cast.sv
`timescale 1ns/10ps
`default_nettype none

module signed_cast #(
    parameter int din_width  = mandel_pkg::sum_width,
    parameter int din_point  = mandel_pkg::data_point,
    parameter int dout_width = mandel_pkg::data_width,
    parameter int dout_point = mandel_pkg::data_point
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  signed [din_width-1:0]  din,
    input  wire                          din_valid,
    output logic signed [dout_width-1:0] dout,
    output logic                         ovf,
    output logic                         dout_valid
);

    logic signed [din_width-1:0] aligned;
    logic                        fits;

    // Floor toward minus infinity.
    assign aligned = din >>> (din_point - dout_point);

    generate
        if (din_width > dout_width) begin : g_narrow
            // Dropped bits must all repeat the sign.
            assign fits = (&aligned[din_width-1:dout_width-1])
                        | ~(|aligned[din_width-1:dout_width-1]);
        end else begin : g_wide
            assign fits = 1'b1;
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (fits) begin
            dout <= dout_width'(aligned);
        end else if (aligned[din_width-1]) begin
            dout <= {1'b1, {(dout_width-1){1'b0}}};
        end else begin
            dout <= {1'b0, {(dout_width-1){1'b1}}};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ovf        <= 1'b0;
            dout_valid <= 1'b0;
        end else begin
            ovf        <= din_valid & ~fits;
            dout_valid <= din_valid;
        end
    end

endmodule

`default_nettype wire

// File: hw/complex_mult.sv
`timescale 1ns/10ps
`default_nettype none

module complex_mult #(
    parameter int din1_width = mandel_pkg::data_width,
    parameter int din2_width = mandel_pkg::data_width
) (
    input  wire                                    clk,
    input  wire                                    rst_n,
    input  wire  signed [din1_width-1:0]           din1_re,
    input  wire  signed [din1_width-1:0]           din1_im,
    input  wire  signed [din2_width-1:0]           din2_re,
    input  wire  signed [din2_width-1:0]           din2_im,
    input  wire                                    din_valid,
    output logic signed [din1_width+din2_width:0]  dout_re,
    output logic signed [din1_width+din2_width:0]  dout_im,
    output logic                                   dout_valid
);

    // Partial products (a + jb)(c + jd).
    logic signed [din1_width+din2_width-1:0] ac;
    logic signed [din1_width+din2_width-1:0] bd;
    logic signed [din1_width+din2_width-1:0] ad;
    logic signed [din1_width+din2_width-1:0] bc;

    logic [mandel_pkg::mult_latency-1:0] valid_sr;

    // Stage 1.
    always_ff @(posedge clk) begin
        ac <= din1_re * din2_re;
        bd <= din1_im * din2_im;
        ad <= din1_re * din2_im;
        bc <= din1_im * din2_re;
    end

    // Stage 2, no rounding.
    always_ff @(posedge clk) begin
        dout_re <= ac - bd;
        dout_im <= ad + bc;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[mandel_pkg::mult_latency-2:0], din_valid};
        end
    end

    assign dout_valid = valid_sr[mandel_pkg::mult_latency-1];

endmodule

`default_nettype wire

// File: hw/mandel_pkg.sv
`default_nettype none

package mandel_pkg;

    // Q8.16 complex components.
    localparam int data_width = 24;
    localparam int data_point = 16;

    // Full-precision product, one bit of headroom for the add/subtract.
    localparam int mult_width = 2 * data_width + 1;

    // Product after dropping data_point fraction bits, plus c.
    localparam int sum_width = 2 * data_width - data_point + 1;

    // Iteration limit and escape count.
    localparam int iter_width = 16;

    // Frame dimensions and pixel coordinates.
    localparam int dim_width = 8;

    // Pipeline depths.
    localparam int mult_latency = 2;
    localparam int loop_latency = 4;

endpackage

`default_nettype wire
